//--- ac97/ac97_cmd_sequencer.sv
module ac97_cmd_sequencer (
  input  logic              clock,
  input  logic              reset,
  input  ac97_pkg::volume_t volume,
  codec_cmd_if.sequencer    cmd,
  pcm_if.sequencer          pcm
);
  import ac97_pkg::*;

  logic [3:0] step;          // wraps at 16
  cmd_word_t  table_word;
  cmd_word_t  command;
  logic       command_valid;
  volume_t    attenuation;

  // codec wants attenuation, 0 is loudest
  assign attenuation = VOLUME_MAX - volume;

  //////////////////////////////////////////////////////////////////////
  // command table
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (step)
      4'd3: begin  // headphone volume, same on both channels
        table_word = {REG_HEADPHONE_VOL, 3'b000, attenuation, 3'b000, attenuation};
      end
      4'd5: begin
        table_word = {REG_PCM_VOL, 16'h0808};  // pcm out gain
      end
      4'd6: begin  // record source, both channels from mic
        table_word = {REG_REC_SELECT, 5'b00000, REC_SOURCE_MIC,
                      5'b00000, REC_SOURCE_MIC};
      end
      4'd7: begin
        table_word = {REG_REC_GAIN, 16'h0F0F};  // max record gain
      end
      4'd9: begin
        table_word = {REG_MIC_VOL, 16'h8048};   // mic +20 dB boost
      end
      4'd10: begin
        table_word = {REG_BEEP_VOL, 16'h0000};
      end
      4'd11: begin
        table_word = {REG_GENERAL, 16'h8000};   // pcm out bypasses 3d mix
      end
      default: begin
        table_word = {REG_VENDOR_ID, 16'h0000}; // step 0 and idle steps
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // step counter
  //////////////////////////////////////////////////////////////////////

  // new entry the cycle after each strobe, engine picks it up at bit 255
  always_ff @(posedge clock) begin
    if (reset) begin
      step          <= 4'd0;
      command       <= {REG_VENDOR_ID, 16'h0000};
      command_valid <= 1'b0;
    end else if (pcm.sample_strobe) begin
      command       <= table_word;
      step          <= step + 4'd1;
      command_valid <= 1'b1;
    end
  end

  assign cmd.cmd_address = command.address;
  assign cmd.cmd_data    = command.data;
  assign cmd.cmd_valid   = command_valid;

endmodule

//--- ac97/ac97_frame_engine.sv
module ac97_frame_engine (
  input  logic        clock,
  input  logic        reset,
  codec_cmd_if.engine cmd,
  pcm_if.engine       pcm,
  output logic        ac97_synch,
  output logic        ac97_sdata_out,
  input  logic        ac97_sdata_in
);
  import ac97_pkg::*;

  // tag plus slots 1 to 4, everything after is zero
  localparam int HEAD_BITS   = TAG_BITS + 4 * SLOT_BITS;     // 96
  localparam int SLOT3_FIRST = TAG_BITS + 2 * SLOT_BITS;     // 56
  localparam int SLOT4_FIRST = SLOT3_FIRST + SLOT_BITS;      // 76
  localparam int ADDR_PAD    = SLOT_BITS - $bits(reg_addr_t);
  localparam int DATA_PAD    = SLOT_BITS - $bits(reg_data_t);
  localparam int SAMPLE_PAD  = SLOT_BITS - SAMPLE_BITS;
  localparam int TAG_PAD     = TAG_BITS - 5;                 // unused slot valids

  localparam bit_count_t LAST_BIT = bit_count_t'(FRAME_BITS - 1);

  bit_count_t bit_count;    // index of the bit now on the wire
  bit_count_t next_count;

  // frame copy, taken at bit 255
  cmd_word_t frame_cmd;
  logic      frame_cmd_valid;
  sample_t   frame_left;
  sample_t   frame_right;
  logic      frame_pcm_valid;
  logic      pcm_armed;     // a play sample has been latched since reset

  logic [TAG_BITS-1:0]  tag;
  slot_t                slot1;
  slot_t                slot2;
  slot_t                slot3;
  slot_t                slot4;
  logic [HEAD_BITS-1:0] frame_head;

  assign next_count = bit_count + 1'b1;  // wraps 255 -> 0

  //////////////////////////////////////////////////////////////////////
  // outgoing frame image
  //////////////////////////////////////////////////////////////////////

  assign tag = {1'b1,                            // frame valid
                frame_cmd_valid, frame_cmd_valid, // slot 1 and 2 valid
                frame_pcm_valid, frame_pcm_valid, // slot 3 and 4 valid
                {TAG_PAD{1'b0}}};

  // slot contents are zeroed when their tag is clear
  assign slot1 = frame_cmd_valid ? {frame_cmd.address, {ADDR_PAD{1'b0}}} : '0;
  assign slot2 = frame_cmd_valid ? {frame_cmd.data, {DATA_PAD{1'b0}}} : '0;
  assign slot3 = frame_pcm_valid ? {frame_left, {SAMPLE_PAD{1'b0}}} : '0;
  assign slot4 = frame_pcm_valid ? {frame_right, {SAMPLE_PAD{1'b0}}} : '0;

  assign frame_head = {tag, slot1, slot2, slot3, slot4};

  // once per frame, mid-frame
  assign pcm.sample_strobe = (bit_count == SAMPLE_STROBE_BIT);

  //////////////////////////////////////////////////////////////////////
  // bit counter, synch and serializer
  //////////////////////////////////////////////////////////////////////

  // outputs are registered from next_count so synch and data line up
  always_ff @(posedge clock) begin
    if (reset) begin
      bit_count       <= LAST_BIT;   // first frame starts right after reset
      ac97_synch      <= 1'b0;
      ac97_sdata_out  <= 1'b0;
      frame_cmd_valid <= 1'b0;
      frame_pcm_valid <= 1'b0;
      pcm_armed       <= 1'b0;
    end else begin
      bit_count  <= next_count;
      ac97_synch <= (next_count < TAG_BITS);  // high over slot 0
      if (next_count < HEAD_BITS)
        ac97_sdata_out <= frame_head[HEAD_BITS-1-next_count];  // msb first
      else
        ac97_sdata_out <= 1'b0;

      if (pcm.sample_strobe)
        pcm_armed <= 1'b1;

      if (bit_count == LAST_BIT) begin
        frame_cmd_valid <= cmd.cmd_valid;
        frame_pcm_valid <= pcm_armed;   // keeps first frame empty
      end
    end
  end

  // payload copy for the next frame
  always_ff @(posedge clock) begin
    if (bit_count == LAST_BIT) begin
      frame_cmd   <= {cmd.cmd_address, cmd.cmd_data};
      frame_left  <= pcm.play_left;
      frame_right <= pcm.play_right;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // deserializer
  //////////////////////////////////////////////////////////////////////

  // sampled in the same cycles that slots 3 and 4 go out
  always_ff @(posedge clock) begin
    if (bit_count >= SLOT3_FIRST && bit_count < SLOT4_FIRST)
      pcm.rec_left <= {pcm.rec_left[SLOT_BITS-2:0], ac97_sdata_in};
    else if (bit_count >= SLOT4_FIRST && bit_count < HEAD_BITS)
      pcm.rec_right <= {pcm.rec_right[SLOT_BITS-2:0], ac97_sdata_in};
  end

endmodule

//--- common/ac97_pkg.sv
package ac97_pkg;

  //////////////////////////////////////////////////////////////////////
  // frame geometry
  //////////////////////////////////////////////////////////////////////

  localparam int FRAME_BITS  = 256;  // bits per ac97 frame
  localparam int TAG_BITS    = 16;   // slot 0
  localparam int SLOT_BITS   = 20;   // slots 1 to 12
  localparam int SAMPLE_BITS = 8;    // user pcm width
  localparam int VOLUME_BITS = 5;

  typedef logic [$clog2(FRAME_BITS)-1:0] bit_count_t;  // 0 to 255
  typedef logic [SLOT_BITS-1:0]          slot_t;
  typedef logic [SAMPLE_BITS-1:0]        sample_t;     // left-justified in a slot
  typedef logic [VOLUME_BITS-1:0]        volume_t;

  localparam volume_t VOLUME_MAX   = '1;    // 31, loudest
  localparam volume_t VOLUME_RESET = 5'd8;

  // sample strobe position within the frame
  localparam bit_count_t SAMPLE_STROBE_BIT = 8'd128;

  // codec held in reset this long after system reset
  localparam int CODEC_RESET_CYCLES = 1024;

  //////////////////////////////////////////////////////////////////////
  // codec register commands
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  typedef struct packed {
    reg_addr_t address;  // goes out in slot 1
    reg_data_t data;     // goes out in slot 2
  } cmd_word_t;

  localparam logic [2:0] REC_SOURCE_MIC = 3'd0;

  localparam reg_addr_t REG_HEADPHONE_VOL = 8'h04;
  localparam reg_addr_t REG_BEEP_VOL      = 8'h0A;
  localparam reg_addr_t REG_MIC_VOL       = 8'h0E;
  localparam reg_addr_t REG_PCM_VOL       = 8'h18;
  localparam reg_addr_t REG_REC_SELECT    = 8'h1A;
  localparam reg_addr_t REG_REC_GAIN      = 8'h1C;
  localparam reg_addr_t REG_GENERAL       = 8'h20;
  localparam reg_addr_t REG_VENDOR_ID     = 8'h80;  // read bit set, harmless filler

endpackage

//--- common/codec_cmd_if.sv
// one codec register command, held steady between sample strobes
interface codec_cmd_if;
  import ac97_pkg::*;

  reg_addr_t cmd_address;
  reg_data_t cmd_data;
  logic      cmd_valid;   // low until the first table entry is out

  modport sequencer (
    output cmd_address,
    output cmd_data,
    output cmd_valid
  );

  modport engine (
    input cmd_address,
    input cmd_data,
    input cmd_valid
  );

endinterface

//--- common/pcm_if.sv
// per-frame sample exchange and frame strobe
interface pcm_if;
  import ac97_pkg::*;

  logic    sample_strobe;  // one cycle at bit 128
  sample_t play_left;      // sampled by engine at bit 255
  sample_t play_right;
  slot_t   rec_left;       // full slot 3 from bit 76 on
  slot_t   rec_right;      // full slot 4 from bit 96 on

  modport engine (
    output sample_strobe,
    input  play_left,
    input  play_right,
    output rec_left,
    output rec_right
  );

  modport user (
    input  sample_strobe,
    output play_left,
    output play_right,
    input  rec_left,
    input  rec_right
  );

  modport sequencer (input sample_strobe);

endinterface

//--- hdl/audio_top.sv
module audio_top #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic              clock,          // ac97 bit clock
  input  logic              reset,
  input  logic              button_up,
  input  logic              button_down,
  input  ac97_pkg::sample_t play_data,
  output ac97_pkg::sample_t rec_data,
  output logic              sample_ready,
  output logic              codec_reset_b,
  output logic              ac97_synch,
  output logic              ac97_sdata_out,
  input  logic              ac97_sdata_in
);
  import ac97_pkg::*;

  localparam int POWER_COUNT_W = $clog2(CODEC_RESET_CYCLES);

  logic [POWER_COUNT_W-1:0] power_count;
  volume_t                  volume;
  sample_t                  play_sample;   // repeats if not refreshed

  codec_cmd_if cmd_bus ();
  pcm_if       pcm_bus ();

  //////////////////////////////////////////////////////////////////////
  // codec power-up delay
  //////////////////////////////////////////////////////////////////////

  // codec_reset_b rises CODEC_RESET_CYCLES after reset drops
  always_ff @(posedge clock) begin
    if (reset) begin
      power_count   <= '0;
      codec_reset_b <= 1'b0;
    end else if (power_count == POWER_COUNT_W'(CODEC_RESET_CYCLES - 1)) begin
      codec_reset_b <= 1'b1;      // counter parks here
    end else begin
      power_count   <= power_count + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (pcm_bus.sample_strobe)
      play_sample <= play_data;
  end

  // mono out on both channels
  assign pcm_bus.play_left  = play_sample;
  assign pcm_bus.play_right = play_sample;

  assign rec_data     = pcm_bus.rec_left[SLOT_BITS-1 -: SAMPLE_BITS];  // left only
  assign sample_ready = pcm_bus.sample_strobe;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  volume_control #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) u_volume_control (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  ac97_cmd_sequencer u_cmd_sequencer (
    .clock(clock),
    .reset(reset),
    .volume(volume),
    .cmd(cmd_bus.sequencer),
    .pcm(pcm_bus.sequencer)
  );

  ac97_frame_engine u_frame_engine (
    .clock(clock),
    .reset(reset),
    .cmd(cmd_bus.engine),
    .pcm(pcm_bus.engine),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

endmodule

//--- hdl/debounce.sv
module debounce #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int COUNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [COUNT_W-1:0] count;      // cycles since last change
  logic               last_noisy;

  always_ff @(posedge clock) begin
    if (reset) begin
      count      <= '0;
      last_noisy <= noisy;
      clean      <= noisy;          // start out agreeing with the pin
    end else if (noisy != last_noisy) begin
      last_noisy <= noisy;          // bounce, start over
      count      <= '0;
    end else if (count == COUNT_W'(DEBOUNCE_CYCLES)) begin
      clean      <= last_noisy;     // stable long enough
    end else begin
      count      <= count + 1'b1;
    end
  end

endmodule

//--- hdl/volume_control.sv
module volume_control #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              button_up,
  input  logic              button_down,
  output ac97_pkg::volume_t volume
);
  import ac97_pkg::*;

  logic up_clean;
  logic down_clean;
  logic up_q;       // previous clean levels
  logic down_q;
  logic up_rise;
  logic down_rise;

  debounce #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) u_debounce_up (
    .clock(clock),
    .reset(reset),
    .noisy(button_up),
    .clean(up_clean)
  );

  debounce #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) u_debounce_down (
    .clock(clock),
    .reset(reset),
    .noisy(button_down),
    .clean(down_clean)
  );

  assign up_rise   = up_clean & ~up_q;
  assign down_rise = down_clean & ~down_q;

  // one step per press, clamped at both ends
  always_ff @(posedge clock) begin
    if (reset) begin
      volume <= VOLUME_RESET;
      up_q   <= up_clean;     // button held through reset is not a press
      down_q <= down_clean;
    end else begin
      up_q   <= up_clean;
      down_q <= down_clean;
      if (up_rise && !down_rise && volume != VOLUME_MAX)
        volume <= volume + 1'b1;
      else if (down_rise && !up_rise && volume != '0)
        volume <= volume - 1'b1;
      // both at once cancel out
    end
  end

endmodule

//--- src.f
common/ac97_pkg.sv
common/codec_cmd_if.sv
common/pcm_if.sv
ac97/ac97_frame_engine.sv
ac97/ac97_cmd_sequencer.sv
hdl/debounce.sv
hdl/volume_control.sv
hdl/audio_top.sv
tb/ac97_codec_model.sv
tb/tb_audio_top.sv

//--- tb/ac97_codec_model.sv
// codec side of the link that decodes each outgoing frame and feeds record samples
module ac97_codec_model #(
  parameter int DRIVE_DELAY = 10
) (
  input  logic             clock,
  input  logic             ac97_synch,
  input  logic             ac97_sdata_out,
  output logic             ac97_sdata_in,
  output ac97_pkg::slot_t  sent_left,     // left sample of the current frame
  output int               frame_count,   // bumps once a frame is decoded
  output logic [15:0]      tag,
  output ac97_pkg::slot_t  slot1,
  output ac97_pkg::slot_t  slot2,
  output ac97_pkg::slot_t  slot3,
  output ac97_pkg::slot_t  slot4,
  output int               frame_length,  // cycles between synch rises
  output int               synch_cycles,
  output int               tail_ones      // set bits after slot 4
);

  logic [95:0]     head;      // tag plus slots 1 to 4 as received
  ac97_pkg::slot_t sent_right;
  int              pos;       // bit index within the frame
  int              synch_n;
  int              tail_n;
  logic            synch_q;
  bit              started;

  initial begin
    ac97_sdata_in = 1'b0;
    frame_count   = 0;
    synch_q       = 1'b0;
    started       = 1'b0;
  end

  always @(posedge clock) begin
    #DRIVE_DELAY;
    if (ac97_synch && !synch_q) begin       // frame start
      if (started) begin
        {tag, slot1, slot2, slot3, slot4} = head;
        frame_length = pos + 1;
        synch_cycles = synch_n;
        tail_ones    = tail_n;
        frame_count <= frame_count + 1;     // lands after the slots and wakes the checker
      end
      started    = 1'b1;
      pos        = 0;
      synch_n    = 0;
      tail_n     = 0;
      head       = '0;
      sent_left  = ac97_pkg::slot_t'($urandom);
      sent_right = ac97_pkg::slot_t'($urandom);
    end else if (started) begin
      pos = pos + 1;
    end
    synch_q = ac97_synch;

    if (started) begin
      if (ac97_synch)
        synch_n = synch_n + 1;
      if (pos < 96)
        head[95-pos] = ac97_sdata_out;      // msb first
      else if (ac97_sdata_out)
        tail_n = tail_n + 1;
      // record slots 3 and 4 with noise everywhere else
      if (pos >= 56 && pos < 76)
        ac97_sdata_in = sent_left[75-pos];
      else if (pos >= 76 && pos < 96)
        ac97_sdata_in = sent_right[95-pos];
      else
        ac97_sdata_in = 1'($urandom_range(0, 1));
    end
  end

endmodule

//--- tb/tb_audio_top.sv
module tb_audio_top;
  import ac97_pkg::*;

  localparam int          CLOCK_PERIOD    = 100;
  localparam int          DRIVE_DELAY     = 10;    // after each rising edge
  localparam int          RESET_CYCLES    = 8;
  localparam int          DEBOUNCE_CYCLES = 16;
  localparam int          RUN_FRAMES      = 150;
  localparam int          TIMEOUT_CYCLES  = 200 * FRAME_BITS;
  localparam logic [31:0] SEED            = 32'h830d9e03;

  logic clock, reset, button_up, button_down;
  logic sample_ready, codec_reset_b, ac97_synch, ac97_sdata_out, ac97_sdata_in;
  sample_t play_data, rec_data;
  slot_t sent_left, slot1, slot2, slot3, slot4;
  logic [15:0] tag;
  int frame_count, frame_length, synch_cycles, tail_ones;

  int         error_count, cycle_count, low_cycles, frames_checked;
  int         last_ready;     // cycle of the previous sample_ready
  int         press_left;     // hold cycles still to go
  bit         press_up, released, locked;
  logic [3:0] step;           // model of the sequencer step
  volume_t    model_volume;
  sample_t    play_q[$];      // one entry per frame from frame 2 on
  volume_t    vol_q[$];
  sample_t    exp_play;
  volume_t    exp_vol;
  cmd_word_t  exp_cmd;

  audio_top #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) UUT (
    .clock(clock), .reset(reset), .button_up(button_up), .button_down(button_down),
    .play_data(play_data), .rec_data(rec_data), .sample_ready(sample_ready),
    .codec_reset_b(codec_reset_b), .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out), .ac97_sdata_in(ac97_sdata_in)
  );

  ac97_codec_model #(.DRIVE_DELAY(DRIVE_DELAY)) codec (
    .clock(clock), .ac97_synch(ac97_synch), .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in), .sent_left(sent_left), .frame_count(frame_count),
    .tag(tag), .slot1(slot1), .slot2(slot2), .slot3(slot3), .slot4(slot4),
    .frame_length(frame_length), .synch_cycles(synch_cycles), .tail_ones(tail_ones)
  );

  // codec register writes per step from the register map
  function automatic cmd_word_t table_command(input logic [3:0] idx, input volume_t vol);
    logic [4:0] att;
    att = 5'd31 - vol;   // attenuation where 0 is loudest
    case (idx)
      4'd3:    return {8'h04, 3'b000, att, 3'b000, att};
      4'd5:    return {8'h18, 16'h0808};
      4'd6:    return {8'h1A, 16'h0000};  // mic on both channels
      4'd7:    return {8'h1C, 16'h0F0F};
      4'd9:    return {8'h0E, 16'h8048};
      4'd10:   return {8'h0A, 16'h0000};
      4'd11:   return {8'h20, 16'h8000};
      default: return {8'h80, 16'h0000};  // vendor id read
    endcase
  endfunction

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  initial begin
    void'($urandom(SEED));
    clock = 1'b0;
    reset = 1'b1;
    button_up = 1'b0;
    button_down = 1'b0;
    play_data = '0;
    model_volume = 5'd8;
    wait (frames_checked >= RUN_FRAMES);
    assert (released) else begin
      $display("codec_reset_b was never released");
      error_count++;
    end
    assert (locked) else begin
      $display("no headphone volume command was ever seen");
      error_count++;
    end
    $display("%0d frames checked, %0d errors", frames_checked, error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // per-cycle reset, stimulus, codec reset and record checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    #DRIVE_DELAY;
    cycle_count++;
    if (cycle_count >= RESET_CYCLES)
      reset = 1'b0;                        // 8 edges seen with reset high
    if (!reset) begin
      if (!codec_reset_b) begin
        assert (!released) else begin
          $display("codec_reset_b went low again after release");
          error_count++;
        end
        low_cycles++;
      end else if (!released) begin
        released = 1'b1;
        assert (low_cycles == CODEC_RESET_CYCLES) else begin
          $display("ERROR %0t: codec reset low %0d cycles", $time, low_cycles);
          error_count++;
        end
      end
      play_data = sample_t'($urandom);     // only the strobe cycle value counts
      if (sample_ready) begin
        if (last_ready > 0) begin
          assert (cycle_count - last_ready == FRAME_BITS) else begin
            $display("ERROR %0t: sample_ready %0d cycles after the previous one", $time,
                     cycle_count - last_ready);
            error_count++;
          end
        end
        last_ready = cycle_count;
        assert (rec_data == sent_left[19:12]) else begin
          $display("ERROR %0t: rec_data %h, sent %h", $time, rec_data, sent_left[19:12]);
          error_count++;
        end
        play_q.push_back(play_data);
        vol_q.push_back(model_volume);     // volume the sequencer loads now
      end
      if (press_left > 0) begin
        press_left--;
        if (press_left == 0) begin         // release once the press has registered
          button_up = 1'b0;
          button_down = 1'b0;
          if (press_up && model_volume != 5'd31)
            model_volume++;
          else if (!press_up && model_volume != 5'd0)
            model_volume--;
        end
      end else if (sample_ready && $urandom_range(0, 3) != 0) begin
        // mostly up in the first half and mostly down after
        press_up = ($urandom_range(0, 3) != 0) ^ (frames_checked >= RUN_FRAMES / 2);
        press_left = $urandom_range(20, 60);
        button_up = press_up;
        button_down = !press_up;
      end
    end
    if (cycle_count >= TIMEOUT_CYCLES + RESET_CYCLES) begin
      $display("timeout after %0d cycles with %0d frames checked and %0d errors",
               cycle_count, frames_checked, error_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per-frame tag, slot and command sequence checks
  //////////////////////////////////////////////////////////////////////

  always @(frame_count) begin
    if (frame_count == 1) begin
      assert (tag[14:0] == 15'h0000 && {slot1, slot2, slot3, slot4} == '0) else begin
        $display("ERROR %0t: first frame tag %h carries valid slots", $time, tag);
        error_count++;
      end
    end else if (frame_count > 1) begin
      exp_play = play_q.pop_front();
      exp_vol = vol_q.pop_front();
      assert (tag == 16'hF800) else begin
        $display("ERROR %0t: frame %0d tag %h", $time, frame_count, tag);
        error_count++;
      end
      assert (slot3 == {exp_play, 12'h000} && slot4 == {exp_play, 12'h000}) else begin
        $display("ERROR %0t: slots 3/4 %h %h, expected %h", $time, slot3, slot4, exp_play);
        error_count++;
      end
      if (!locked && slot1[19:12] == 8'h04) begin
        locked = 1'b1;
        step = 4'd3;
      end else if (locked) begin
        step = step + 4'd1;
      end
      if (locked) begin
        exp_cmd = table_command(step, exp_vol);
        assert (slot1 == {exp_cmd.address, 12'h000} && slot2 == {exp_cmd.data, 4'h0})
        else begin
          $display("ERROR %0t: step %0d command %h %h, expected %h", $time, step,
                   slot1, slot2, exp_cmd);
          error_count++;
        end
      end
    end
    if (frame_count > 0) begin
      assert (frame_length == FRAME_BITS && synch_cycles == 16 && tail_ones == 0) else begin
        $display("ERROR %0t: frame %0d length %0d synch %0d tail %0d", $time,
                 frame_count, frame_length, synch_cycles, tail_ones);
        error_count++;
      end
      frames_checked++;
    end
  end

endmodule
